/* hp35CtlPkg.sv */
// Word timing constants and the parser, opcode and execution state enums
package hp35CtlPkg;

    // ----------------------------------------------------------
    // Word cycle timing
    // ----------------------------------------------------------
    localparam int WordBits  = 56;                      // Bit times in one word cycle
    localparam int BitTimeW  = 6;                       // Wide enough to count 0 to 55
    localparam int InstrBits = 10;                      // Instruction length on IS

    localparam int BitT5  = 5;                          // Status search may begin after this bit
    localparam int BitT14 = 14;                         // Pointer step follows this bit
    localparam int BitT18 = 18;                         // Last bit of the execution window
    localparam int BitT26 = 26;                         // Last bit of address output
    localparam int BitT45 = 45;                         // First instruction bit arrives on IS
    localparam int BitT54 = BitT45 + InstrBits - 1;     // Last instruction bit ends word select

    // ----------------------------------------------------------
    // Parser states, one per node of the decision tree
    // ----------------------------------------------------------
    // Each name lists the bits seen so far, oldest bit first
    typedef enum logic [4:0] {
        psIdle,                                         // Waiting for b45
        ps1x,     ps0x,
        ps00x,    ps001x,   ps000x,   ps0000x,
        ps01x,    ps010x,   ps0100x,
        ps0010x,  ps00100x, ps00101x,
        ps0011x,  ps00110x, ps00111x,
        ps0001x,
        psBusy                                          // Instruction in flight until opDone
    } parseState_t;

    // Decoded instruction classes handed from parser to sequencer
    typedef enum logic [3:0] {
        opJsb, opBrh,                                   // Type 1
        opArithP, opArithWp, opArithW,                  // Type 2 word selects
        opSst, opRst, opIst, opCst,                     // Type 3
        opSpt, opIpt, opPtd, opPti,                     // Type 4
        opNop                                           // Type 5, Type 6 and anything else
    } opcode_t;

    // ----------------------------------------------------------
    // Execution states
    // ----------------------------------------------------------
    typedef enum logic [4:0] {
        esIdle,
        esJsb, esJsbWait,                               // Jump to subroutine
        esBrhWait, esBrhOut,                            // Branch on carry clear
        esArithP, esArithWp, esArithWait,               // Arithmetic word select and wait
        esSstWait, esRstWait, esIstWait, esCstWait,     // Status ops waiting for b5
        esStDecr, esStThis, esStDone,                   // Shared status locate path
        esCstThis,                                      // Clear all status to end of field
        esSpt, esSptDone,                               // Set pointer
        esIpt, esIptSetC, esIptRstC,                    // Interrogate pointer
        esPtdWait, esPtdNow,                            // Pointer decrement
        esPtiWait, esPtiNow,                            // Pointer increment
        esNopWait,                                      // No-op waits for default address
        esAddrOut                                       // Default ROM address goes out
    } execState_t;

endpackage

/* wordTimer.sv */
// Word-cycle bit-time counter and the decoded bit-time strobes
`timescale 1ns/100ps

module wordTimer (
    input  logic                             PHI2,
    input  logic                             pwor,
    output logic [hp35CtlPkg::BitTimeW-1:0] bitTime,   // Current bit time within the word
    output logic                             b5,
    output logic                             b14,
    output logic                             b18,
    output logic                             b26,
    output logic                             b45,
    output logic                             b54
);

    import hp35CtlPkg::*;

    localparam logic [BitTimeW-1:0] LastBit = BitTimeW'(WordBits - 1);

    // ----------------------------------------------------------
    // System counter
    // ----------------------------------------------------------
    // Stands in for the shared system counter of the calculator chips
    always_ff @(posedge PHI2 or posedge pwor) begin
        if (pwor) begin
            bitTime <= '0;                              // Word cycle restarts at bit 0
        end else if (bitTime == LastBit) begin
            bitTime <= '0;                              // Wrap after bit 55
        end else begin
            bitTime <= bitTime + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Timing decoder
    // ----------------------------------------------------------
    // Each strobe is true for the single cycle of its bit time
    assign b5  = (bitTime == BitTimeW'(BitT5));         // Start of status search
    assign b14 = (bitTime == BitTimeW'(BitT14));        // Pointer step begins next cycle
    assign b18 = (bitTime == BitTimeW'(BitT18));        // End of execution window
    assign b26 = (bitTime == BitTimeW'(BitT26));        // End of address output
    assign b45 = (bitTime == BitTimeW'(BitT45));        // First instruction bit on IS
    assign b54 = (bitTime == BitTimeW'(BitT54));        // Last instruction bit on IS

endmodule

/* opcodeParser.sv */
// Serial decision-tree parser that classifies the instruction arriving on IS
`timescale 1ns/100ps

module opcodeParser (
    input  logic                PHI2,
    input  logic                pwor,
    input  logic                IS,                     // Serial instruction, first bit at b45
    input  logic                b45,
    input  logic                opDone,                 // Sequencer has finished the instruction
    output logic                opStart,                // One-cycle pulse, opcode valid with it
    output hp35CtlPkg::opcode_t opcode
);

    import hp35CtlPkg::*;

    parseState_t state;
    parseState_t nextState;
    logic        leafHit;                               // This cycle's bit completes a decision
    opcode_t     leafOp;                                // Class chosen at the leaf

    // ----------------------------------------------------------
    // Instruction parsing tree
    // ----------------------------------------------------------
    // One IS bit is consumed per cycle and every leaf heads to busy
    always_comb begin
        nextState = state;
        leafHit   = 1'b0;
        leafOp    = opNop;
        case (state)
            psIdle:   if (b45) nextState = IS ? ps1x : ps0x;     // Type 1 test
            ps1x: begin                                           // JSB or BRH
                leafHit = 1'b1;
                leafOp  = IS ? opBrh : opJsb;
            end
            ps0x:     nextState = IS ? ps01x : ps00x;            // Type 2 test
            ps01x: begin                                          // First word select bit
                if (IS) begin
                    leafHit = 1'b1;
                    leafOp  = opArithW;
                end else begin
                    nextState = ps010x;
                end
            end
            ps010x: begin                                         // Second word select bit
                if (IS) begin
                    leafHit = 1'b1;
                    leafOp  = opArithW;
                end else begin
                    nextState = ps0100x;
                end
            end
            ps0100x: begin                                        // Pointer only or up to pointer
                leafHit = 1'b1;
                leafOp  = IS ? opArithWp : opArithP;
            end
            ps00x:    nextState = IS ? ps001x : ps000x;          // Type 3 and 4 against 5 and 6
            ps001x:   nextState = IS ? ps0011x : ps0010x;        // Status against pointer
            ps0010x:  nextState = IS ? ps00101x : ps00100x;
            ps00100x: begin
                leafHit = 1'b1;
                leafOp  = IS ? opRst : opSst;
            end
            ps00101x: begin
                leafHit = 1'b1;
                leafOp  = IS ? opCst : opIst;
            end
            ps0011x:  nextState = IS ? ps00111x : ps00110x;
            ps00110x: begin
                leafHit = 1'b1;
                leafOp  = IS ? opIpt : opSpt;
            end
            ps00111x: begin
                leafHit = 1'b1;
                leafOp  = IS ? opPti : opPtd;
            end
            ps000x:   nextState = IS ? ps0001x : ps0000x;        // Type 5 against Type 6
            ps0001x, ps0000x: begin
                leafHit = 1'b1;                                   // Only the default address
                leafOp  = opNop;                                  // output is left to do
            end
            psBusy:   if (opDone) nextState = psIdle;            // One instruction per word
            default:  nextState = psIdle;
        endcase
        if (leafHit) begin
            nextState = psBusy;
        end
    end

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------
    always_ff @(posedge PHI2 or posedge pwor) begin
        if (pwor) begin
            state   <= psIdle;
            opStart <= 1'b0;
        end else begin
            state   <= nextState;
            opStart <= leafHit;                         // Rises the cycle after the leaf bit
        end
    end

    // The class is captured with the pulse and held while busy
    always_ff @(posedge PHI2) begin
        if (leafHit) begin
            opcode <= leafOp;
        end
    end

endmodule

/* execSequencer.sv */
// Execution state machine that waits on bit times and qualifiers and drives the control lines
`timescale 1ns/100ps

module execSequencer (
    input  logic                PHI2,
    input  logic                pwor,
    input  logic                opStart,                // Accepted only while idle
    input  hp35CtlPkg::opcode_t opcode,
    input  logic                b5,
    input  logic                b14,
    input  logic                b18,
    input  logic                b26,
    input  logic                b54,
    input  logic                carryFf,                // Branch is taken only when clear
    input  logic                stqZero,                // Selected status bit is at the end
    input  logic                isEqPtr,                // Pointer field matches the pointer
    output logic                opDone,
    output logic                jsb,
    output logic                brh,
    output logic                ptOnly,
    output logic                up2Pt,
    output logic                arithW,
    output logic                istW,
    output logic                stDecN,
    output logic                sst,
    output logic                rst,
    output logic                ist,
    output logic                spt,
    output logic                iptR,
    output logic                iptS,
    output logic                ptd,
    output logic                pti
);

    import hp35CtlPkg::*;

    execState_t state;
    execState_t nextState;
    opcode_t    opReg;                                  // Remembers the status target

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            esIdle: begin
                if (opStart) begin
                    case (opcode)
                        opJsb:     nextState = esJsb;
                        opBrh:     nextState = esBrhWait;
                        opArithP:  nextState = esArithP;
                        opArithWp: nextState = esArithWp;
                        opArithW:  nextState = esArithWait;
                        opSst:     nextState = esSstWait;
                        opRst:     nextState = esRstWait;
                        opIst:     nextState = esIstWait;
                        opCst:     nextState = esCstWait;
                        opSpt:     nextState = esSpt;
                        opIpt:     nextState = esIpt;
                        opPtd:     nextState = esPtdWait;
                        opPti:     nextState = esPtiWait;
                        default:   nextState = esNopWait;
                    endcase
                end
            end
            // Type 1
            esJsb:       if (b54) nextState = esJsbWait;           // Return address is saved
            esJsbWait:   if (b18) nextState = esAddrOut;
            esBrhWait:   if (b18) nextState = carryFf ? esAddrOut : esBrhOut;
            esBrhOut:    if (b26) nextState = esIdle;              // Branch address replaces default
            // Type 2
            esArithP, esArithWp: begin
                if (b54) nextState = esArithWait;                  // Word select is done
            end
            esArithWait: if (b18) nextState = esAddrOut;           // A&R chip does the work
            // Type 3 shares one locate path after b5
            esSstWait, esRstWait, esIstWait, esCstWait: begin
                if (b5) nextState = esStDecr;
            end
            esStDecr: begin
                if (stqZero) nextState = (opReg == opCst) ? esCstThis : esStThis;
            end
            esStThis:    nextState = b18 ? esAddrOut : esStDone;   // One cycle of the operation
            esStDone:    if (b18) nextState = esAddrOut;
            esCstThis:   if (b18) nextState = esAddrOut;           // Clears to the end of the field
            // Type 4
            esSpt:       if (b54) nextState = esSptDone;
            esSptDone:   if (b18) nextState = esAddrOut;
            esIpt: begin
                if (!isEqPtr) begin
                    nextState = esIptRstC;                         // Mismatch seen so reset carry
                end else if (b54) begin
                    nextState = esIptSetC;                         // Matched the whole field
                end
            end
            esIptSetC, esIptRstC: begin
                if (b18) nextState = esAddrOut;
            end
            esPtdWait:   if (b14) nextState = esPtdNow;
            esPtiWait:   if (b14) nextState = esPtiNow;
            esPtdNow, esPtiNow: begin
                if (b18) nextState = esAddrOut;                    // Four-cycle pointer step
            end
            esNopWait:   if (b18) nextState = esAddrOut;
            esAddrOut:   if (b26) nextState = esIdle;              // Default ROM address is out
            default:     nextState = esIdle;
        endcase
    end

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------
    always_ff @(posedge PHI2 or posedge pwor) begin
        if (pwor) begin
            state <= esIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge PHI2) begin
        if (state == esIdle && opStart) begin
            opReg <= opcode;                            // Held until the next instruction
        end
    end

    // ----------------------------------------------------------
    // Control lines
    // ----------------------------------------------------------
    // Both exits toward the parser finish at b26
    assign opDone = b26 && (state == esAddrOut || state == esBrhOut);

    assign jsb    = (state == esJsb);
    assign brh    = (state == esBrhOut);                // Serial branch address on Ia
    assign ptOnly = (state == esArithP);
    assign up2Pt  = (state == esArithWp);
    assign arithW = (state == esArithWait);
    assign istW   = (state == esIstWait);               // Shifter holds off for interrogate
    assign stDecN = (state == esStDecr);
    assign sst    = (state == esStThis) && (opReg == opSst);
    assign rst    = ((state == esStThis) && (opReg == opRst)) || (state == esCstThis);
    assign ist    = (state == esStThis) && (opReg == opIst);
    assign spt    = (state == esSpt);
    assign iptR   = (state == esIptRstC);
    assign iptS   = (state == esIptSetC);
    assign ptd    = (state == esPtdNow);
    assign pti    = (state == esPtiNow);

endmodule

/* microController.sv */
// Top level joining the word timer, opcode parser and execution sequencer
`timescale 1ns/100ps

module microController (
    input  logic PHI2,
    input  logic pwor,
    input  logic IS,                                    // Serial instruction from ROM
    input  logic carryFf,
    input  logic stqZero,
    input  logic isEqPtr,
    output logic jsb,
    output logic brh,
    output logic ptOnly,
    output logic up2Pt,
    output logic arithW,
    output logic istW,
    output logic stDecN,
    output logic sst,
    output logic rst,
    output logic ist,
    output logic spt,
    output logic iptR,
    output logic iptS,
    output logic ptd,
    output logic pti
);

    import hp35CtlPkg::*;

    // Bit-time strobes shared by parser and sequencer
    logic    b5;
    logic    b14;
    logic    b18;
    logic    b26;
    logic    b45;
    logic    b54;
    logic    opStart;                                   // Parser hands over a decoded class
    logic    opDone;                                    // Sequencer releases the parser
    opcode_t opcode;

    // ----------------------------------------------------------
    // Timing decoder
    // ----------------------------------------------------------
    // The raw count is left open here and only the strobes are used
    wordTimer i_timer (
        .PHI2(PHI2), .pwor(pwor), .bitTime(),
        .b5(b5), .b14(b14), .b18(b18), .b26(b26), .b45(b45), .b54(b54)
    );

    // ----------------------------------------------------------
    // Instruction parsing and execution
    // ----------------------------------------------------------
    opcodeParser i_parser (
        .PHI2(PHI2), .pwor(pwor), .IS(IS), .b45(b45), .opDone(opDone),
        .opStart(opStart), .opcode(opcode)
    );

    execSequencer i_sequencer (
        .PHI2(PHI2), .pwor(pwor), .opStart(opStart), .opcode(opcode),
        .b5(b5), .b14(b14), .b18(b18), .b26(b26), .b54(b54),
        .carryFf(carryFf), .stqZero(stqZero), .isEqPtr(isEqPtr), .opDone(opDone),
        .jsb(jsb), .brh(brh), .ptOnly(ptOnly), .up2Pt(up2Pt), .arithW(arithW),
        .istW(istW), .stDecN(stDecN), .sst(sst), .rst(rst), .ist(ist), .spt(spt),
        .iptR(iptR), .iptS(iptS), .ptd(ptd), .pti(pti)
    );

endmodule

/* ctlTbVectors.svh */
// Stimulus table of instruction words, qualifier settings and decoded classes
`ifndef CTL_TB_VECTORS_SVH
`define CTL_TB_VECTORS_SVH

// Each row holds the instruction word with bit 0 first out on IS, the index of the leaf bit,
// carryFf, isEqPtr, the decoded class and a row name
localparam int NumRows = 20;

task automatic loadTable();
    // Type 1
    addRow(10'h169, 1, 1'b0, 1'b0, opJsb,     "jsb");
    addRow(10'h16B, 1, 1'b0, 1'b0, opBrh,     "brh c=0");
    addRow(10'h16B, 1, 1'b1, 1'b0, opBrh,     "brh c=1");
    // Type 2 with both encodings of the whole word
    addRow(10'h0AE, 2, 1'b0, 1'b0, opArithW,  "arith w");
    addRow(10'h0CA, 3, 1'b0, 1'b0, opArithW,  "arith w2");
    addRow(10'h262, 4, 1'b0, 1'b0, opArithP,  "arith p");
    addRow(10'h272, 4, 1'b0, 1'b0, opArithWp, "arith wp");
    // Type 3
    addRow(10'h244, 5, 1'b0, 1'b0, opSst,     "sst");
    addRow(10'h264, 5, 1'b0, 1'b0, opRst,     "rst");
    addRow(10'h254, 5, 1'b0, 1'b0, opIst,     "ist");
    addRow(10'h274, 5, 1'b0, 1'b0, opCst,     "cst");
    // Type 4
    addRow(10'h24C, 5, 1'b0, 1'b0, opSpt,     "spt");
    addRow(10'h26C, 5, 1'b0, 1'b1, opIpt,     "ipt eq");
    addRow(10'h26C, 5, 1'b0, 1'b0, opIpt,     "ipt ne");
    addRow(10'h25C, 5, 1'b0, 1'b0, opPtd,     "ptd");
    addRow(10'h27C, 5, 1'b0, 1'b0, opPti,     "pti");
    // Type 6 then Type 5 prefixes each followed by a normal instruction
    addRow(10'h2D0, 4, 1'b1, 1'b1, opNop,     "type 6");
    addRow(10'h169, 1, 1'b0, 1'b0, opJsb,     "jsb again");
    addRow(10'h2D8, 4, 1'b0, 1'b1, opNop,     "type 5");
    addRow(10'h244, 5, 1'b0, 1'b0, opSst,     "sst again");
endtask

`endif

/* ctlTb.sv */
// Testbench top with clock, reset, table-driven stimulus, window checks and timeout
`timescale 1ns/100ps

module ctlTb;

    import hp35CtlPkg::*;

    localparam int NumLines = 15;
    localparam int Never    = -1;                       // Marks a line that never went high

    logic PHI2;
    logic pwor;
    logic IS;
    logic carryFf;
    logic stqZero;
    logic isEqPtr;
    logic jsb, brh, ptOnly, up2Pt, arithW, istW, stDecN, sst, rst, ist;
    logic spt, iptR, iptS, ptd, pti;
    logic [NumLines-1:0] lines;                         // Index 0 is jsb

    // Row table filled from the included file
    logic [9:0] vecWord[$];
    int         vecLeaf[$];
    logic       vecCarry[$];
    logic       vecEq[$];
    opcode_t    vecOp[$];
    string      vecName[$];

    int expFirst[NumLines];
    int expLast[NumLines];
    int gotFirst[NumLines];
    int gotLast[NumLines];
    int errorCount;
    int checkCount;
    int cycleCount;

    `include "ctlTbVectors.svh"

    localparam int CycleLimit = NumRows * 2 * WordBits + 20;

    microController i_dut (
        .PHI2(PHI2), .pwor(pwor), .IS(IS), .carryFf(carryFf), .stqZero(stqZero),
        .isEqPtr(isEqPtr), .jsb(jsb), .brh(brh), .ptOnly(ptOnly), .up2Pt(up2Pt),
        .arithW(arithW), .istW(istW), .stDecN(stDecN), .sst(sst), .rst(rst), .ist(ist),
        .spt(spt), .iptR(iptR), .iptS(iptS), .ptd(ptd), .pti(pti)
    );

    assign lines = {pti, ptd, iptS, iptR, spt, ist, rst, sst, stDecN, istW,
                    arithW, up2Pt, ptOnly, brh, jsb};

    always #50 PHI2 = ~PHI2;                            // 100 ns period

    // ----------------------------------------------------------
    // Table and expected windows
    // ----------------------------------------------------------
    task automatic addRow(input logic [9:0] word, input int leaf, input logic carry,
                          input logic eq, input opcode_t op, input string name);
        vecWord.push_back(word);
        vecLeaf.push_back(leaf);
        vecCarry.push_back(carry);
        vecEq.push_back(eq);
        vecOp.push_back(op);
        vecName.push_back(name);
    endtask

    function automatic string lineName(input int idx);
        string names[NumLines];
        names = '{"jsb", "brh", "ptOnly", "up2Pt", "arithW", "istW", "stDecN", "sst",
                  "rst", "ist", "spt", "iptR", "iptS", "ptd", "pti"};
        return names[idx];
    endfunction

    task automatic setWindow(input int idx, input int first, input int last);
        expFirst[idx] = first;
        expLast[idx]  = last;
    endtask

    // Times count from bit 0 of the word carrying the instruction, so b18 of the
    // next word is WordBits + 18
    task automatic computeWindows(input opcode_t op, input int leaf, input logic carry,
                                  input logic eq, input int stqAt);
        int start;
        int nextB18;
        int hit;
        start   = BitT45 + leaf + 2;                    // Leaf bit, opStart, then the op state
        nextB18 = WordBits + BitT18;
        hit     = WordBits + stqAt + 1;                 // One cycle after stqZero is seen
        for (int i = 0; i < NumLines; i++) setWindow(i, Never, Never);
        case (op)
            opJsb:     setWindow(0, start, BitT54);
            opBrh:     if (!carry) setWindow(1, nextB18 + 1, WordBits + BitT26);
            opArithP: begin
                setWindow(2, start, BitT54);
                setWindow(4, BitT54 + 1, nextB18);
            end
            opArithWp: begin
                setWindow(3, start, BitT54);
                setWindow(4, BitT54 + 1, nextB18);
            end
            opArithW:  setWindow(4, start, nextB18);
            opSst, opRst, opIst, opCst: begin
                setWindow(6, WordBits + BitT5 + 1, hit - 1);
                if (op == opSst) setWindow(7, hit, hit);
                if (op == opRst) setWindow(8, hit, hit);
                if (op == opCst) setWindow(8, hit, nextB18);   // Clears to end of field
                if (op == opIst) begin
                    setWindow(9, hit, hit);
                    setWindow(5, start, WordBits + BitT5);
                end
            end
            opSpt:     setWindow(10, start, BitT54);
            opIpt:     if (eq) setWindow(12, BitT54 + 1, nextB18);
                       else setWindow(11, start + 1, nextB18);
            opPtd:     setWindow(13, WordBits + BitT14 + 1, nextB18);
            opPti:     setWindow(14, WordBits + BitT14 + 1, nextB18);
            default:   ;                                // No line may move
        endcase
    endtask

    // ----------------------------------------------------------
    // Stimulus loop
    // ----------------------------------------------------------
    initial begin
        int e;
        int stqAt;
        int rowErrors;
        void'($urandom(42077));
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        PHI2    = 1'b0;
        pwor    = 1'b1;
        IS      = 1'b0;
        carryFf = 1'b0;
        stqZero = 1'b0;
        isEqPtr = 1'b0;
        loadTable();
        repeat (5) @(posedge PHI2);
        pwor <= 1'b0;                                   // The cycle after this edge is bit 0
        for (int row = 0; row < vecWord.size(); row++) begin
            stqAt = 6 + ($urandom % 11);                // Somewhere in b6 to b16
            computeWindows(vecOp[row], vecLeaf[row], vecCarry[row], vecEq[row], stqAt);
            for (int i = 0; i < NumLines; i++) begin
                gotFirst[i] = Never;
                gotLast[i]  = Never;
            end
            for (e = 0; e < 2 * WordBits; e++) begin
                IS      <= (e >= BitT45 && e <= BitT54) ? vecWord[row][e - BitT45] : 1'b0;
                carryFf <= vecCarry[row];
                isEqPtr <= vecEq[row];
                stqZero <= (e >= WordBits + stqAt) && (e <= WordBits + BitT18 + 1);
                @(negedge PHI2);                        // Outputs are settled mid-cycle
                if (e <= WordBits + BitT26) begin
                    for (int i = 0; i < NumLines; i++) begin
                        if (lines[i]) begin
                            if (gotFirst[i] == Never) gotFirst[i] = e;
                            gotLast[i] = e;
                        end
                    end
                end
                @(posedge PHI2);
            end
            rowErrors = 0;
            for (int i = 0; i < NumLines; i++) begin
                checkCount += 2;
                assert (gotFirst[i] == expFirst[i]) else begin
                    $display("** Error row %0d %s: %s first = %0h, expected %0h", row,
                             vecName[row], lineName(i), gotFirst[i], expFirst[i]);
                    rowErrors++;
                end
                assert (gotLast[i] == expLast[i]) else begin
                    $display("** Error row %0d %s: %s last = %0h, expected %0h", row,
                             vecName[row], lineName(i), gotLast[i], expLast[i]);
                    rowErrors++;
                end
            end
            errorCount += rowErrors;
            $display("row %0d %-10s stq at b%0d: %s", row, vecName[row], stqAt,
                     (rowErrors == 0) ? "ok" : "mismatch");
        end
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // ----------------------------------------------------------
    // Timeout
    // ----------------------------------------------------------
    always @(posedge PHI2) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the run went past %0d clock cycles", CycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

/* tb.f */
+incdir+.
hp35CtlPkg.sv
wordTimer.sv
opcodeParser.sv
execSequencer.sv
microController.sv
ctlTb.sv
